// ==== flist.f ====
+incdir+verif
verilog/rs_pkg.sv
verilog/prio_enc.sv
verilog/generic_rs.sv
verilog/alu_eu.sv
verilog/rs_exec_top.sv
verif/tb_rs_exec.sv

// ==== Bender.yml ====
package:
  name: rs_exec_slice

sources:
  - files:
      - verilog/rs_pkg.sv
      - verilog/prio_enc.sv
      - verilog/generic_rs.sv
      - verilog/alu_eu.sv
      - verilog/rs_exec_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_rs_exec.sv

// ==== verif/tb_alu_model.svh ====
// Reference ALU model for the testbench, included inside the testbench module body
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// Expected result and exception of one operation, worked out in 64-bit arithmetic
function automatic rs_pkg::eu_res_t alu_ref(
    input logic [rs_pkg::EU_CTL_LEN-1:0] op,
    input logic [rs_pkg::XLEN-1:0]       a,
    input logic [rs_pkg::XLEN-1:0]       b
);
    longint          sa;
    longint          sb;
    longint          wide;
    logic            ovf;
    rs_pkg::eu_res_t r;

    sa   = longint'($signed(a));
    sb   = longint'($signed(b));
    wide = 0;
    ovf  = 1'b0;
    r    = '0;
    case (op)
        rs_pkg::ADD: begin
            wide     = sa + sb;
            r.result = wide[31:0];
            // True sum does not fit in 32 signed bits
            ovf      = (wide[32] != wide[31]);
        end
        rs_pkg::SUB: begin
            wide     = sa - sb;
            r.result = wide[31:0];
            ovf      = (wide[32] != wide[31]);
        end
        rs_pkg::AND: r.result = a & b;
        rs_pkg::OR:  r.result = a | b;
        rs_pkg::XOR: r.result = a ^ b;
        rs_pkg::SLT: r.result = (sa < sb) ? 32'd1 : 32'd0;
        // Shift amount is the low 5 bits only
        rs_pkg::SLL: r.result = a << b[4:0];
        rs_pkg::SRL: r.result = a >> b[4:0];
        default:     r.result = '0;
    endcase
    r.except_raised = ovf;
    r.except_code   = ovf ? rs_pkg::EXC_OVERFLOW : rs_pkg::EXC_NONE;
    return r;
endfunction

`endif

// ==== verif/tb_rs_exec.sv ====
// Self-checking testbench for the issue slice, run with the file list and tb_rs_exec as top
`timescale 1ns/1ps
`default_nettype none

module tb_rs_exec;

    import rs_pkg::*;

    localparam int RS_DEPTH   = 8;
    localparam int TAGS       = 1 << ROB_IDX_LEN;
    localparam int CLK_PERIOD = 40;
    localparam int IN_DELAY   = 2;
    // 40 independent, 40 chained, 8 same-cycle pair ops, 16 overflow, back-pressure, 6 + 16 flush
    localparam int NUM_OPS    = 40 + 40 + 8 + 16 + RS_DEPTH + 6 + 16;

    // DUT signals
    logic        clk_i;
    logic        rst_n_i;
    logic        flush_i;
    logic        issue_valid_i;
    logic        issue_ready_o;
    issue_req_t  issue_i;
    logic        cdb_valid_o;
    logic        cdb_ready_i;
    cdb_t        cdb_o;

    // Per-tag expectations
    logic [TAGS-1:0] pending;
    eu_res_t         exp_res [TAGS];

    integer seed;
    int     last_tag;
    int     n_issued;
    int     n_bcast;
    int     n_exc;
    int     err_data;
    int     err_exc;
    int     err_proto;

    `include "tb_alu_model.svh"

    rs_exec_top #(
        .RS_DEPTH (RS_DEPTH)
    ) rs_exec_top_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .issue_i       (issue_i),
        .cdb_valid_o   (cdb_valid_o),
        .cdb_ready_i   (cdb_ready_i),
        .cdb_o         (cdb_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Free tag from a random starting point, -1 when all are in use
    function automatic int pick_free_tag();
        int start;
        int t;
        start = $unsigned($random(seed)) % TAGS;
        for (int k = 0; k < TAGS; k++) begin
            t = (start + k) % TAGS;
            if (!pending[t]) return t;
        end
        return -1;
    endfunction

    // Pending producer that will not fault, -1 when none
    function automatic int pick_producer();
        int start;
        int t;
        start = $unsigned($random(seed)) % TAGS;
        for (int k = 0; k < TAGS; k++) begin
            t = (start + k) % TAGS;
            if (pending[t] && !exp_res[t].except_raised) return t;
        end
        return -1;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #IN_DELAY;
        end
    endtask

    // Offer one op, called and left 2 ns after a rising edge
    task automatic issue_op(
        input logic [EU_CTL_LEN-1:0] op,
        input logic [XLEN-1:0]       a,
        input logic [XLEN-1:0]       b,
        input bit                    use_deps,
        input int                    force_src
    );
        int          dest;
        int          src1;
        int          src2;
        issue_req_t  req;
        logic [31:0] va;
        logic [31:0] vb;

        // Ready only moves on edges, so ready seen now means transfer on the next edge
        dest = pick_free_tag();
        while (!issue_ready_o || dest < 0) begin
            wait_cycles(1);
            dest = pick_free_tag();
        end
        src1 = -1;
        src2 = -1;
        if (force_src >= 0 && pending[force_src] && !exp_res[force_src].except_raised) begin
            src1 = force_src;
        end else if (use_deps && (($random(seed) & 1) == 1)) begin
            src1 = pick_producer();
        end
        if (use_deps && (($random(seed) & 1) == 1)) begin
            src2 = pick_producer();
        end
        // Waiting operands take the producer's expected result
        va = (src1 >= 0) ? exp_res[src1].result : a;
        vb = (src2 >= 0) ? exp_res[src2].result : b;

        // Tags and values that should be ignored carry junk
        req.eu_ctl    = op;
        req.rs1_ready = (src1 < 0);
        req.rs1_idx   = (src1 < 0) ? ROB_IDX_LEN'($random(seed)) : ROB_IDX_LEN'(src1);
        req.rs1_value = (src1 < 0) ? a : XLEN'($random(seed));
        req.rs2_ready = (src2 < 0);
        req.rs2_idx   = (src2 < 0) ? ROB_IDX_LEN'($random(seed)) : ROB_IDX_LEN'(src2);
        req.rs2_value = (src2 < 0) ? b : XLEN'($random(seed));
        req.dest_idx  = ROB_IDX_LEN'(dest);

        pending[dest] = 1'b1;
        exp_res[dest] = alu_ref(op, va, vb);
        last_tag      = dest;
        n_issued++;

        issue_i       = req;
        issue_valid_i = 1'b1;
        wait_cycles(1);
        issue_valid_i = 1'b0;
    endtask

    // Every issued tag must come back once
    task automatic wait_drain();
        while (|pending) begin
            wait_cycles(1);
        end
        assert (n_issued == n_bcast) else begin
            err_proto++;
            $display("[ERROR] %0t: %0d ops issued, %0d broadcasts", $time, n_issued, n_bcast);
        end
        n_issued = 0;
        n_bcast  = 0;
    endtask

    // Checker samples mid-cycle, the values seen here complete on the next rising edge
    always @(negedge clk_i) begin
        if (rst_n_i && cdb_valid_o && cdb_ready_i) begin
            assert (pending[cdb_o.idx]) else begin
                err_proto++;
                $display("Broadcast for tag %0d at %0t with no operation pending on it",
                         cdb_o.idx, $time);
            end
            if (pending[cdb_o.idx]) begin
                assert (cdb_o.data == exp_res[cdb_o.idx].result) else begin
                    err_data++;
                    $display("[ERROR] %0t: tag %0d data %h, expected %h", $time, cdb_o.idx,
                             cdb_o.data, exp_res[cdb_o.idx].result);
                end
                assert (cdb_o.except_raised == exp_res[cdb_o.idx].except_raised &&
                        cdb_o.except_code == exp_res[cdb_o.idx].except_code) else begin
                    err_exc++;
                    $display("[ERROR] %0t: tag %0d exception %b/%0d, expected %b/%0d", $time,
                             cdb_o.idx, cdb_o.except_raised, cdb_o.except_code,
                             exp_res[cdb_o.idx].except_raised, exp_res[cdb_o.idx].except_code);
                end
            end
            if (cdb_o.except_raised) n_exc++;
            pending[cdb_o.idx] = 1'b0;
            n_bcast++;
        end
    end

    // Watchdog scaled to the op count
    initial begin
        #(NUM_OPS * 60 * CLK_PERIOD);
        $display("Timeout, run still going after %0d ns", NUM_OPS * 60 * CLK_PERIOD);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int         accepted;
        int         prod;
        logic [2:0] rop;

        seed          = 32'he091_0f3c;
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        cdb_ready_i   = 1'b1;
        pending       = '0;
        n_issued      = 0;
        n_bcast       = 0;
        n_exc         = 0;
        err_data      = 0;
        err_exc       = 0;
        err_proto     = 0;
        last_tag      = 0;

        repeat (4) @(posedge clk_i);
        #IN_DELAY;
        rst_n_i = 1'b1;
        wait_cycles(1);
        assert (issue_ready_o && !cdb_valid_o) else begin
            err_proto++;
            $display("[ERROR] %0t: handshake outputs wrong after reset", $time);
        end

        // Independent ops over all opcodes
        for (int i = 0; i < 40; i++) begin
            issue_op(3'(i % 8), $random(seed), $random(seed), 1'b0, -1);
        end
        wait_drain();

        // Random dependency chains
        for (int i = 0; i < 40; i++) begin
            rop = $random(seed);
            issue_op(rop, $random(seed), $random(seed), 1'b1, -1);
        end
        wait_drain();

        // Consumer accepted on the producer's broadcast edge
        for (int i = 0; i < 4; i++) begin
            issue_op(ADD, $random(seed) & 32'hffff, $random(seed) & 32'hffff, 1'b0, -1);
            prod = last_tag;
            while (!(cdb_valid_o && cdb_o.idx == prod)) begin
                wait_cycles(1);
            end
            issue_op(XOR, 32'd0, $random(seed), 1'b0, prod);
        end
        wait_drain();

        // Signed overflow, three of every four cases overflow
        n_exc = 0;
        for (int i = 0; i < 16; i++) begin
            case (i % 4)
                0: issue_op(ADD, 32'h4000_0000 | ($random(seed) & 32'h3fff_ffff),
                            32'h4000_0000 | ($random(seed) & 32'h3fff_ffff), 1'b0, -1);
                1: issue_op(SUB, 32'h4000_0000 | ($random(seed) & 32'h3fff_ffff),
                            32'h8000_0000 | ($random(seed) & 32'h3fff_ffff), 1'b0, -1);
                2: issue_op(ADD, 32'h8000_0000 | ($random(seed) & 32'h3fff_ffff),
                            32'h8000_0000 | ($random(seed) & 32'h3fff_ffff), 1'b0, -1);
                default: issue_op(SUB, $random(seed) & 32'hffff, $random(seed) & 32'hffff,
                                  1'b0, -1);
            endcase
        end
        wait_drain();
        assert (n_exc == 12) else begin
            err_exc++;
            $display("[ERROR] %0t: %0d overflow broadcasts, expected 12", $time, n_exc);
        end

        // CDB stalled until the station fills
        cdb_ready_i = 1'b0;
        accepted    = 0;
        for (int i = 0; i < RS_DEPTH + 4; i++) begin
            if (!issue_ready_o) break;
            rop = $random(seed);
            issue_op(rop, $random(seed), $random(seed), 1'b1, -1);
            accepted++;
        end
        wait_cycles(30);
        assert (accepted <= RS_DEPTH && !issue_ready_o && n_bcast == 0) else begin
            err_proto++;
            $display("[ERROR] %0t: %0d accepted, ready %b, %0d broadcasts while stalled",
                     $time, accepted, issue_ready_o, n_bcast);
        end
        cdb_ready_i = 1'b1;
        wait_drain();

        // Flush with ops waiting and in the ALU
        cdb_ready_i = 1'b0;
        for (int i = 0; i < 6; i++) begin
            rop = $random(seed);
            issue_op(rop, $random(seed), $random(seed), 1'b1, -1);
        end
        wait_cycles(2);
        flush_i = 1'b1;
        wait_cycles(1);
        flush_i     = 1'b0;
        pending     = '0;
        n_issued    = 0;
        n_bcast     = 0;
        cdb_ready_i = 1'b1;
        wait_cycles(20);
        assert (n_bcast == 0 && issue_ready_o) else begin
            err_proto++;
            $display("[ERROR] %0t: %0d broadcasts after flush, ready %b", $time, n_bcast,
                     issue_ready_o);
        end
        n_bcast = 0;
        for (int i = 0; i < 16; i++) begin
            rop = $random(seed);
            issue_op(rop, $random(seed), $random(seed), 1'b1, -1);
        end
        wait_drain();

        $display("Errors: data %0d, exception %0d, protocol %0d", err_data, err_exc, err_proto);
        if (err_data + err_exc + err_proto == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/rs_exec_top.sv ====
// Top level of the issue slice, joins station and ALU and loops the CDB back to the snoop port
`timescale 1ns/1ps
`default_nettype none

module rs_exec_top #(
    parameter int unsigned RS_DEPTH = 8
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,

    // Issue port
    input  logic                issue_valid_i,
    output logic                issue_ready_o,
    input  rs_pkg::issue_req_t  issue_i,

    // CDB
    output logic                cdb_valid_o,
    input  logic                cdb_ready_i,
    output rs_pkg::cdb_t        cdb_o
);

    import rs_pkg::*;

    // Station to ALU
    logic                          eu_valid;
    logic                          eu_ready;
    eu_req_t                       eu_req;
    logic [$clog2(RS_DEPTH)-1:0]   eu_entry_idx;

    // ALU to station
    logic                          res_valid;
    eu_res_t                       res;
    logic [$clog2(RS_DEPTH)-1:0]   res_entry_idx;

    // Only accepted broadcasts wake waiting ops
    logic                          snoop_valid;

    assign snoop_valid = cdb_valid_o & cdb_ready_i;

    generic_rs #(
        .RS_DEPTH (RS_DEPTH)
    ) u_rs (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .issue_valid_i   (issue_valid_i),
        .issue_ready_o   (issue_ready_o),
        .issue_i         (issue_i),
        .eu_valid_o      (eu_valid),
        .eu_ready_i      (eu_ready),
        .eu_req_o        (eu_req),
        .eu_entry_idx_o  (eu_entry_idx),
        .res_valid_i     (res_valid),
        .res_i           (res),
        .res_entry_idx_i (res_entry_idx),
        .cdb_valid_o     (cdb_valid_o),
        .cdb_ready_i     (cdb_ready_i),
        .cdb_o           (cdb_o),
        .snoop_valid_i   (snoop_valid),
        .snoop_i         (cdb_o)
    );

    alu_eu #(
        .RS_DEPTH (RS_DEPTH)
    ) u_alu (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .req_valid_i     (eu_valid),
        .req_ready_o     (eu_ready),
        .req_i           (eu_req),
        .req_entry_idx_i (eu_entry_idx),
        .res_valid_o     (res_valid),
        .res_o           (res),
        .res_entry_idx_o (res_entry_idx)
    );

endmodule

`default_nettype wire

// ==== verilog/alu_eu.sv ====
// Two-stage pipelined integer ALU fed by the station, returns results with the entry index
`timescale 1ns/1ps
`default_nettype none

module alu_eu #(
    parameter int unsigned RS_DEPTH = 8
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          flush_i,

    // Request from the station
    input  logic                          req_valid_i,
    output logic                          req_ready_o,
    input  rs_pkg::eu_req_t               req_i,
    input  logic [$clog2(RS_DEPTH)-1:0]   req_entry_idx_i,

    // Result strobe back to the station
    output logic                          res_valid_o,
    output rs_pkg::eu_res_t               res_o,
    output logic [$clog2(RS_DEPTH)-1:0]   res_entry_idx_o
);

    import rs_pkg::*;

    localparam int unsigned RS_IDX_LEN = $clog2(RS_DEPTH);

    // Stage 1 operand registers
    logic                    s1_valid_q;
    eu_req_t                 s1_req_q;
    logic [RS_IDX_LEN-1:0]   s1_idx_q;

    // Stage 2 result registers
    logic                    s2_valid_q;
    eu_res_t                 s2_res_q;
    logic [RS_IDX_LEN-1:0]   s2_idx_q;

    // Stage 2 combinational result
    alu_op_e                 op;
    logic [XLEN-1:0]         sum;
    logic [XLEN-1:0]         diff;
    logic [XLEN-1:0]         result;
    logic                    ovf;

    // Fixed latency pipe, never stalls
    assign req_ready_o = 1'b1;

    // Stage valids, a flush kills everything in flight
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= req_valid_i;
            s2_valid_q <= s1_valid_q;
        end
    end

    assign op   = alu_op_e'(s1_req_q.eu_ctl);
    assign sum  = s1_req_q.rs1 + s1_req_q.rs2;
    assign diff = s1_req_q.rs1 - s1_req_q.rs2;

    // Operation decode, signed overflow only on add and subtract
    always_comb begin
        result = sum;
        ovf    = 1'b0;
        case (op)
            ADD: begin
                result = sum;
                ovf    = (s1_req_q.rs1[XLEN-1] == s1_req_q.rs2[XLEN-1]) &&
                         (sum[XLEN-1] != s1_req_q.rs1[XLEN-1]);
            end
            SUB: begin
                result = diff;
                ovf    = (s1_req_q.rs1[XLEN-1] != s1_req_q.rs2[XLEN-1]) &&
                         (diff[XLEN-1] != s1_req_q.rs1[XLEN-1]);
            end
            AND: result = s1_req_q.rs1 & s1_req_q.rs2;
            OR:  result = s1_req_q.rs1 | s1_req_q.rs2;
            XOR: result = s1_req_q.rs1 ^ s1_req_q.rs2;
            SLT: result = {{(XLEN-1){1'b0}}, $signed(s1_req_q.rs1) < $signed(s1_req_q.rs2)};
            SLL: result = s1_req_q.rs1 << s1_req_q.rs2[4:0];
            SRL: result = s1_req_q.rs1 >> s1_req_q.rs2[4:0];
            default: result = sum;
        endcase
    end

    // Payload registers
    always_ff @(posedge clk_i) begin
        s1_req_q               <= req_i;
        s1_idx_q               <= req_entry_idx_i;
        s2_res_q.result        <= result;
        s2_res_q.except_raised <= ovf;
        s2_res_q.except_code   <= ovf ? EXC_OVERFLOW : EXC_NONE;
        s2_idx_q               <= s1_idx_q;
    end

    assign res_valid_o     = s2_valid_q;
    assign res_o           = s2_res_q;
    assign res_entry_idx_o = s2_idx_q;

    // Strobed results are fully defined
    a_res_known: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        res_valid_o |-> !$isunknown({res_o, res_entry_idx_o})
    ) else $error("ALU result carries unknown bits");

endmodule

`default_nettype wire

// ==== verilog/generic_rs.sv ====
// Reservation station holding waiting ALU ops, woken by CDB snooping and retired over the CDB
`timescale 1ns/1ps
`default_nettype none

module generic_rs #(
    parameter int unsigned RS_DEPTH = 8
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          flush_i,

    // Issue port
    input  logic                          issue_valid_i,
    output logic                          issue_ready_o,
    input  rs_pkg::issue_req_t            issue_i,

    // Dispatch to the execution unit
    output logic                          eu_valid_o,
    input  logic                          eu_ready_i,
    output rs_pkg::eu_req_t               eu_req_o,
    output logic [$clog2(RS_DEPTH)-1:0]   eu_entry_idx_o,

    // Result strobe from the execution unit
    input  logic                          res_valid_i,
    input  rs_pkg::eu_res_t               res_i,
    input  logic [$clog2(RS_DEPTH)-1:0]   res_entry_idx_i,

    // Broadcast towards the CDB
    output logic                          cdb_valid_o,
    input  logic                          cdb_ready_i,
    output rs_pkg::cdb_t                  cdb_o,

    // Snooped CDB traffic
    input  logic                          snoop_valid_i,
    input  rs_pkg::cdb_t                  snoop_i
);

    import rs_pkg::*;

    localparam int unsigned RS_IDX_LEN = $clog2(RS_DEPTH);

    // Entry payload without the status flags
    typedef struct packed {
        logic [EU_CTL_LEN-1:0]  eu_ctl;
        logic [ROB_IDX_LEN-1:0] rs1_idx;
        logic [XLEN-1:0]        rs1_value;
        logic [ROB_IDX_LEN-1:0] rs2_idx;
        logic [XLEN-1:0]        rs2_value;
        logic [ROB_IDX_LEN-1:0] res_idx;
        logic [XLEN-1:0]        res_value;
        logic                   except_raised;
        logic [EXCEPT_LEN-1:0]  except_code;
    } rs_entry_t;

    rs_entry_t               entries_q [RS_DEPTH];

    // Per-entry status flags
    logic [RS_DEPTH-1:0]     valid_q;
    logic [RS_DEPTH-1:0]     busy_q;
    logic [RS_DEPTH-1:0]     rs1_rdy_q;
    logic [RS_DEPTH-1:0]     rs2_rdy_q;
    logic [RS_DEPTH-1:0]     res_rdy_q;

    // Candidate masks for the three selectors
    logic [RS_DEPTH-1:0]     free_a;
    logic [RS_DEPTH-1:0]     ex_ready_a;
    logic [RS_DEPTH-1:0]     done_a;

    // Snoop wakeups of stored operands
    logic [RS_DEPTH-1:0]     wake1_a;
    logic [RS_DEPTH-1:0]     wake2_a;

    // Selected indexes
    logic [RS_IDX_LEN-1:0]   new_idx;
    logic [RS_IDX_LEN-1:0]   ex_idx;
    logic [RS_IDX_LEN-1:0]   cdb_idx;
    logic                    new_idx_valid;
    logic                    ex_idx_valid;
    logic                    cdb_idx_valid;

    // Handshake events
    logic                    rs_insert;
    logic                    rs_ex;
    logic                    rs_pop;

    // Only a fault-free snoop wakes waiting operands
    logic                    snoop_ok;

    // Insert bypass of a same-cycle broadcast
    logic                    ins_rs1_rdy;
    logic                    ins_rs2_rdy;
    logic [XLEN-1:0]         ins_rs1_value;
    logic [XLEN-1:0]         ins_rs2_value;

    assign snoop_ok = snoop_valid_i & ~snoop_i.except_raised;

    // Selector inputs and stored-operand tag match
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            free_a[i]     = ~valid_q[i];
            ex_ready_a[i] = valid_q[i] & ~busy_q[i] & rs1_rdy_q[i] & rs2_rdy_q[i];
            done_a[i]     = valid_q[i] & res_rdy_q[i];
            wake1_a[i]    = valid_q[i] & ~rs1_rdy_q[i] & snoop_ok &
                            (entries_q[i].rs1_idx == snoop_i.idx);
            wake2_a[i]    = valid_q[i] & ~rs2_rdy_q[i] & snoop_ok &
                            (entries_q[i].rs2_idx == snoop_i.idx);
        end
    end

    // An operand arriving not ready may still be caught on the bus this cycle
    assign ins_rs1_rdy   = issue_i.rs1_ready | (snoop_ok & (issue_i.rs1_idx == snoop_i.idx));
    assign ins_rs2_rdy   = issue_i.rs2_ready | (snoop_ok & (issue_i.rs2_idx == snoop_i.idx));
    assign ins_rs1_value = issue_i.rs1_ready ? issue_i.rs1_value : snoop_i.data;
    assign ins_rs2_value = issue_i.rs2_ready ? issue_i.rs2_value : snoop_i.data;

    // Lowest free entry takes the next issued op
    prio_enc #(
        .N (RS_DEPTH)
    ) u_free_enc (
        .lines_i (free_a),
        .enc_o   (new_idx),
        .valid_o (new_idx_valid)
    );

    // Lowest entry with both operands and no dispatch yet
    prio_enc #(
        .N (RS_DEPTH)
    ) u_ex_enc (
        .lines_i (ex_ready_a),
        .enc_o   (ex_idx),
        .valid_o (ex_idx_valid)
    );

    // Lowest entry holding a finished result
    prio_enc #(
        .N (RS_DEPTH)
    ) u_cdb_enc (
        .lines_i (done_a),
        .enc_o   (cdb_idx),
        .valid_o (cdb_idx_valid)
    );

    // Handshakes
    assign issue_ready_o = new_idx_valid;
    assign eu_valid_o    = ex_idx_valid;
    assign cdb_valid_o   = cdb_idx_valid;
    assign rs_insert     = issue_valid_i & new_idx_valid;
    assign rs_ex         = ex_idx_valid & eu_ready_i;
    assign rs_pop        = cdb_idx_valid & cdb_ready_i;

    // Status flags that a flush drops all at once
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q   <= '0;
            busy_q    <= '0;
            rs1_rdy_q <= '0;
            rs2_rdy_q <= '0;
            res_rdy_q <= '0;
        end else if (flush_i) begin
            valid_q   <= '0;
            busy_q    <= '0;
            rs1_rdy_q <= '0;
            rs2_rdy_q <= '0;
            res_rdy_q <= '0;
        end else begin
            // Dispatched entry is not picked again
            if (rs_ex) begin
                busy_q[ex_idx] <= 1'b1;
            end
            if (rs_insert) begin
                valid_q[new_idx]   <= 1'b1;
                busy_q[new_idx]    <= 1'b0;
                rs1_rdy_q[new_idx] <= ins_rs1_rdy;
                rs2_rdy_q[new_idx] <= ins_rs2_rdy;
                res_rdy_q[new_idx] <= 1'b0;
            end
            // Entry is freed on the broadcast edge
            if (rs_pop) begin
                valid_q[cdb_idx] <= 1'b0;
            end
            if (res_valid_i) begin
                res_rdy_q[res_entry_idx_i] <= 1'b1;
            end
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (wake1_a[i]) begin
                    rs1_rdy_q[i] <= 1'b1;
                end
                if (wake2_a[i]) begin
                    rs2_rdy_q[i] <= 1'b1;
                end
            end
        end
    end

    // Payload writes qualified by the same events as the flags
    always_ff @(posedge clk_i) begin
        if (rs_insert) begin
            entries_q[new_idx].eu_ctl    <= issue_i.eu_ctl;
            entries_q[new_idx].rs1_idx   <= issue_i.rs1_idx;
            entries_q[new_idx].rs1_value <= ins_rs1_value;
            entries_q[new_idx].rs2_idx   <= issue_i.rs2_idx;
            entries_q[new_idx].rs2_value <= ins_rs2_value;
            entries_q[new_idx].res_idx   <= issue_i.dest_idx;
        end
        if (res_valid_i) begin
            entries_q[res_entry_idx_i].res_value     <= res_i.result;
            entries_q[res_entry_idx_i].except_raised <= res_i.except_raised;
            entries_q[res_entry_idx_i].except_code   <= res_i.except_code;
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (wake1_a[i]) begin
                entries_q[i].rs1_value <= snoop_i.data;
            end
            if (wake2_a[i]) begin
                entries_q[i].rs2_value <= snoop_i.data;
            end
        end
    end

    // Read port towards the ALU
    assign eu_req_o.eu_ctl = entries_q[ex_idx].eu_ctl;
    assign eu_req_o.rs1    = entries_q[ex_idx].rs1_value;
    assign eu_req_o.rs2    = entries_q[ex_idx].rs2_value;
    assign eu_entry_idx_o  = ex_idx;

    // Read port towards the CDB
    assign cdb_o.idx           = entries_q[cdb_idx].res_idx;
    assign cdb_o.data          = entries_q[cdb_idx].res_value;
    assign cdb_o.except_raised = entries_q[cdb_idx].except_raised;
    assign cdb_o.except_code   = entries_q[cdb_idx].except_code;

    // The ALU only returns results for entries it was handed
    a_res_owned: assert property (
        @(posedge clk_i) disable iff (!rst_n_i || flush_i)
        res_valid_i |-> (valid_q[res_entry_idx_i] && busy_q[res_entry_idx_i]
                         && !res_rdy_q[res_entry_idx_i])
    ) else $error("Result for entry %0d that is not in flight", res_entry_idx_i);

    // Accepted issue always lands in a free slot
    a_no_insert_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        rs_insert |-> !valid_q[new_idx]
    ) else $error("Insertion into occupied entry %0d", new_idx);

endmodule

`default_nettype wire

// ==== verilog/prio_enc.sv ====
// Lowest-index-first priority encoder, used by the station to pick free, ready and done entries
`timescale 1ns/1ps
`default_nettype none

module prio_enc #(
    parameter int unsigned N = 8
) (
    input  logic [N-1:0]                           lines_i,
    output logic [((N > 1) ? $clog2(N) : 1)-1:0]   enc_o,
    output logic                                   valid_o
);

    localparam int unsigned IDX_LEN = (N > 1) ? $clog2(N) : 1;

    // Scan from the top so the lowest set line wins
    always_comb begin
        enc_o = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (lines_i[i]) begin
                enc_o = i[IDX_LEN-1:0];
            end
        end
    end

    // Any set line gives a usable index
    assign valid_o = |lines_i;

endmodule

`default_nettype wire

// ==== verilog/rs_pkg.sv ====
// Widths, ALU operation codes, exception codes and bus structs shared by the issue slice
`default_nettype none

package rs_pkg;

    // Data word and tag widths
    localparam int unsigned XLEN        = 32;
    localparam int unsigned ROB_IDX_LEN = 4;

    // Execution control and exception code widths
    localparam int unsigned EU_CTL_LEN  = 3;
    localparam int unsigned EXCEPT_LEN  = 2;

    // ALU operations, shifts take the low 5 bits of rs2
    typedef enum logic [EU_CTL_LEN-1:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLT = 3'd5,
        SLL = 3'd6,
        SRL = 3'd7
    } alu_op_e;

    // Exception codes carried on the CDB
    typedef enum logic [EXCEPT_LEN-1:0] {
        EXC_NONE     = 2'd0,
        EXC_OVERFLOW = 2'd1
    } except_e;

    // One operation offered at issue (81 bits)
    typedef struct packed {
        logic [EU_CTL_LEN-1:0]  eu_ctl;
        logic                   rs1_ready;
        logic [ROB_IDX_LEN-1:0] rs1_idx;
        logic [XLEN-1:0]        rs1_value;
        logic                   rs2_ready;
        logic [ROB_IDX_LEN-1:0] rs2_idx;
        logic [XLEN-1:0]        rs2_value;
        logic [ROB_IDX_LEN-1:0] dest_idx;
    } issue_req_t;

    // One CDB broadcast (39 bits)
    typedef struct packed {
        logic [ROB_IDX_LEN-1:0] idx;
        logic [XLEN-1:0]        data;
        logic                   except_raised;
        logic [EXCEPT_LEN-1:0]  except_code;
    } cdb_t;

    // Operands sent to the ALU (67 bits)
    typedef struct packed {
        logic [EU_CTL_LEN-1:0]  eu_ctl;
        logic [XLEN-1:0]        rs1;
        logic [XLEN-1:0]        rs2;
    } eu_req_t;

    // ALU result (35 bits)
    typedef struct packed {
        logic [XLEN-1:0]        result;
        logic                   except_raised;
        logic [EXCEPT_LEN-1:0]  except_code;
    } eu_res_t;

endpackage

`default_nettype wire
